// File: include/mipsCore_cfg.svh
`ifndef MIPSCORE_CFG_SVH
`define MIPSCORE_CFG_SVH

// data and address width
`define WORD_W 32

// architectural register count, register 0 included
`define NUM_REGS 32

// JAL writes its return address here
`define LINK_REG 31

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: source/isaPkg.sv
`default_nettype none

`include "mipsCore_cfg.svh"

package isaPkg;

    typedef logic [`WORD_W-1:0]           wordT;
    typedef logic [$clog2(`NUM_REGS)-1:0] regAddrT;
    typedef logic [4:0]                   shamtT;

    // major opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcodeE;

    // R-type function codes
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } functE;

    // R-type layout, I and J types overlay the low 16 or 26 bits
    typedef struct packed {
        logic [5:0] opcode;
        regAddrT    rs;
        regAddrT    rt;
        regAddrT    rd;
        shamtT      shamt;
        logic [5:0] funct;
    } instrT;

endpackage

`default_nettype wire

// File: source/pipePkg.sv
`default_nettype none

package pipePkg;

    import isaPkg::*;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } aluOpE;

    // destination register choice
    typedef enum logic [1:0] {DST_RT, DST_RD, DST_LINK} regDstE;

    // writeback source
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wbSrcE;

    // execute operand source
    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwdSelE;

    typedef struct packed {
        logic   regWrite;
        regDstE regDst;
        logic   aluSrcImm;
        logic   zeroExtend;
        aluOpE  aluOp;
        wbSrcE  wbSrc;
        logic   memRead;
        logic   memWrite;
        logic   branchEq;
        logic   branchNe;
        logic   jump;
    } ctrlT;

    // rd holds the already selected destination
    typedef struct packed {
        ctrlT    ctrl;
        wordT    rsVal;
        wordT    rtVal;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
        shamtT   shamt;
        wordT    imm;
        wordT    pcPlus8;
    } idExT;

    typedef struct packed {
        logic    regWrite;
        wbSrcE   wbSrc;
        logic    memRead;
        logic    memWrite;
        wordT    aluRes;
        wordT    storeData;
        regAddrT dst;
        wordT    pcPlus8;
    } exMemT;

    typedef struct packed {
        logic    regWrite;
        wbSrcE   wbSrc;
        wordT    aluRes;
        wordT    loadData;
        wordT    pcPlus8;
        regAddrT dst;
        wordT    pc;
    } memWbT;

endpackage

`default_nettype wire

// File: source/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  isaPkg::wordT  instr_i,
    output pipePkg::ctrlT ctrl_o
);
    import isaPkg::*;
    import pipePkg::*;

    instrT ins;

    assign ins = instr_i;

    always_comb begin
        // all-zero bundle is a bubble
        ctrl_o = '0;
        case (opcodeE'(ins.opcode))
            OP_RTYPE: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.regDst = DST_RD;
                case (functE'(ins.funct))
                    F_ADDU:  ctrl_o.aluOp = ALU_ADD;
                    F_SUBU:  ctrl_o.aluOp = ALU_SUB;
                    F_AND:   ctrl_o.aluOp = ALU_AND;
                    F_OR:    ctrl_o.aluOp = ALU_OR;
                    F_XOR:   ctrl_o.aluOp = ALU_XOR;
                    F_SLT:   ctrl_o.aluOp = ALU_SLT;
                    F_SLL:   ctrl_o.aluOp = ALU_SLL;
                    default: ctrl_o.regWrite = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
            end
            OP_ANDI: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.zeroExtend = 1'b1;
                ctrl_o.aluOp = ALU_AND;
            end
            OP_ORI: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.zeroExtend = 1'b1;
                ctrl_o.aluOp = ALU_OR;
            end
            OP_LUI: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.aluOp = ALU_LUI;
            end
            OP_LW: begin
                ctrl_o.regWrite = 1'b1;
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.memRead = 1'b1;
                ctrl_o.wbSrc = WB_MEM;
            end
            OP_SW: begin
                ctrl_o.aluSrcImm = 1'b1;
                ctrl_o.memWrite = 1'b1;
            end
            OP_BEQ: ctrl_o.branchEq = 1'b1;
            OP_BNE: ctrl_o.branchNe = 1'b1;
            OP_J:   ctrl_o.jump = 1'b1;
            OP_JAL: begin
                ctrl_o.jump = 1'b1;
                ctrl_o.regWrite = 1'b1;
                ctrl_o.regDst = DST_LINK;
                ctrl_o.wbSrc = WB_LINK;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: source/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_cfg.svh"

module regFile (
    input  logic            clk,
    input  logic            arstN_i,
    input  isaPkg::regAddrT raddrA_i,
    input  isaPkg::regAddrT raddrB_i,
    input  logic            we_i,
    input  isaPkg::regAddrT waddr_i,
    input  isaPkg::wordT    wdata_i,
    output isaPkg::wordT    rdataA_o,
    output isaPkg::wordT    rdataB_o
);
    import isaPkg::*;

    // register 0 has no storage
    wordT regs [1:`NUM_REGS-1];

    // write-through so decode sees the value retiring this cycle
    function automatic wordT readReg(input regAddrT addr);
        if (addr == '0) begin
            return '0;
        end
        if (we_i && (addr == waddr_i)) begin
            return wdata_i;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        rdataA_o = readReg(raddrA_i);
        rdataB_o = readReg(raddrB_i);
    end

endmodule

`default_nettype wire

// File: source/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  pipePkg::aluOpE op_i,
    input  isaPkg::wordT   a_i,
    input  isaPkg::wordT   b_i,
    input  isaPkg::shamtT  shamt_i,
    output isaPkg::wordT   y_o
);
    import isaPkg::*;
    import pipePkg::*;

    always_comb begin
        case (op_i)
            ALU_SUB: y_o = a_i - b_i;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_XOR: y_o = a_i ^ b_i;
            // signed compare
            ALU_SLT: y_o = wordT'($signed(a_i) < $signed(b_i));
            // shift takes rt on the b side
            ALU_SLL: y_o = b_i << shamt_i;
            ALU_LUI: y_o = {b_i[15:0], 16'h0000};
            // add wraps, no overflow trap
            default: y_o = a_i + b_i;
        endcase
    end

endmodule

`default_nettype wire

// File: source/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  isaPkg::regAddrT rsD_i,
    input  isaPkg::regAddrT rtD_i,
    input  pipePkg::ctrlT   ctrlD_i,
    input  pipePkg::idExT   idEx_i,
    input  pipePkg::exMemT  exMem_i,
    input  logic            wbWe_i,
    input  isaPkg::regAddrT wbReg_i,
    output logic            stallF_o,
    output logic            stallD_o,
    output logic            flushE_o,
    output pipePkg::fwdSelE fwdA_o,
    output pipePkg::fwdSelE fwdB_o,
    output logic            brFwdA_o,
    output logic            brFwdB_o
);
    import isaPkg::*;
    import pipePkg::*;

    logic isBranch;
    logic usesRt;
    logic loadUse;
    logic branchDep;

    // a later stage writes a register the decode instruction reads
    function automatic logic hitsDecode(input logic en, input regAddrT dst, input logic rtToo);
        return en && (dst != '0) && ((dst == rsD_i) || (rtToo && (dst == rtD_i)));
    endfunction

    // memory stage wins over writeback
    function automatic fwdSelE pickFwd(input regAddrT src);
        if ((src != '0) && exMem_i.regWrite && (exMem_i.dst == src)) begin
            return FWD_MEM;
        end
        if ((src != '0) && wbWe_i && (wbReg_i == src)) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        isBranch = ctrlD_i.branchEq || ctrlD_i.branchNe;
        usesRt = !ctrlD_i.aluSrcImm || ctrlD_i.memWrite || isBranch;
        loadUse = hitsDecode(idEx_i.ctrl.memRead, idEx_i.rd, usesRt);
        // compare runs in decode, so results still in execute or a load in memory must wait
        branchDep = isBranch && (hitsDecode(idEx_i.ctrl.regWrite, idEx_i.rd, 1'b1) ||
                                 hitsDecode(exMem_i.memRead, exMem_i.dst, 1'b1));
        stallF_o = loadUse || branchDep;
        stallD_o = stallF_o;
        flushE_o = stallF_o;
        fwdA_o = pickFwd(idEx_i.rs);
        fwdB_o = pickFwd(idEx_i.rt);
        brFwdA_o = exMem_i.regWrite && (exMem_i.dst != '0) && (exMem_i.dst == rsD_i);
        brFwdB_o = exMem_i.regWrite && (exMem_i.dst != '0) && (exMem_i.dst == rtD_i);
    end

endmodule

`default_nettype wire

// File: source/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_cfg.svh"

module fetchStage (
    input  logic          clk,
    input  logic          arstN_i,
    input  logic          stallF_i,
    input  logic          stallD_i,
    input  isaPkg::wordT  imemData_i,
    input  pipePkg::ctrlT ctrl_i,
    input  isaPkg::wordT  rsVal_i,
    input  isaPkg::wordT  rtVal_i,
    input  isaPkg::wordT  fwdData_i,
    input  logic          fwdA_i,
    input  logic          fwdB_i,
    output isaPkg::wordT  imemAddr_o,
    output isaPkg::wordT  instrD_o,
    output isaPkg::wordT  pcPlus4D_o
);
    import isaPkg::*;
    import pipePkg::*;

    wordT pcF;
    wordT pcPlus4F;
    wordT pcNext;
    wordT cmpA;
    wordT cmpB;
    wordT immSext;
    wordT branchTarget;
    wordT jumpTarget;
    logic takeBranch;

    assign imemAddr_o = pcF;
    assign pcPlus4F = pcF + wordT'(4);

    // branch compare in decode
    assign cmpA = fwdA_i ? fwdData_i : rsVal_i;
    assign cmpB = fwdB_i ? fwdData_i : rtVal_i;
    assign takeBranch = (ctrl_i.branchEq && (cmpA == cmpB)) ||
                        (ctrl_i.branchNe && (cmpA != cmpB));

    // targets are relative to the delay slot address
    assign immSext = {{16{instrD_o[15]}}, instrD_o[15:0]};
    assign branchTarget = pcPlus4D_o + {immSext[29:0], 2'b00};
    assign jumpTarget = {pcPlus4D_o[31:28], instrD_o[25:0], 2'b00};

    always_comb begin
        if (ctrl_i.jump) begin
            pcNext = jumpTarget;
        end else if (takeBranch) begin
            pcNext = branchTarget;
        end else begin
            pcNext = pcPlus4F;
        end
    end

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            pcF <= `RESET_PC;
        end else if (!stallF_i) begin
            pcF <= pcNext;
        end
    end

    // IF/ID register, reset loads a NOP
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            instrD_o <= '0;
            pcPlus4D_o <= '0;
        end else if (!stallD_i) begin
            instrD_o <= imemData_i;
            pcPlus4D_o <= pcPlus4F;
        end
    end

endmodule

`default_nettype wire

// File: source/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_cfg.svh"

module executeStage (
    input  logic            clk,
    input  logic            arstN_i,
    input  logic            flushE_i,
    input  pipePkg::ctrlT   ctrl_i,
    input  isaPkg::wordT    rsVal_i,
    input  isaPkg::wordT    rtVal_i,
    input  isaPkg::wordT    instrD_i,
    input  isaPkg::wordT    pcPlus4D_i,
    input  pipePkg::fwdSelE fwdA_i,
    input  pipePkg::fwdSelE fwdB_i,
    input  isaPkg::wordT    memFwd_i,
    input  isaPkg::wordT    wbFwd_i,
    output pipePkg::idExT   idEx_o,
    output pipePkg::exMemT  exMem_o
);
    import isaPkg::*;
    import pipePkg::*;

    instrT ins;
    idExT  idExNext;
    wordT  srcA;
    wordT  srcB;
    wordT  storeData;
    wordT  aluY;

    function automatic wordT fwdMux(input fwdSelE sel, input wordT regVal);
        case (sel)
            FWD_MEM: return memFwd_i;
            FWD_WB:  return wbFwd_i;
            default: return regVal;
        endcase
    endfunction

    assign ins = instrD_i;

    // extension and destination are settled before the ID/EX register
    always_comb begin
        idExNext.ctrl = ctrl_i;
        idExNext.rsVal = rsVal_i;
        idExNext.rtVal = rtVal_i;
        idExNext.rs = ins.rs;
        idExNext.rt = ins.rt;
        idExNext.shamt = ins.shamt;
        case (ctrl_i.regDst)
            DST_RD:   idExNext.rd = ins.rd;
            DST_LINK: idExNext.rd = regAddrT'(`LINK_REG);
            default:  idExNext.rd = ins.rt;
        endcase
        if (ctrl_i.zeroExtend) begin
            idExNext.imm = {16'h0000, instrD_i[15:0]};
        end else begin
            idExNext.imm = {{16{instrD_i[15]}}, instrD_i[15:0]};
        end
        idExNext.pcPlus8 = pcPlus4D_i + wordT'(4);
    end

    // flush inserts a bubble behind a stalled decode
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            idEx_o <= '0;
        end else if (flushE_i) begin
            idEx_o <= '0;
        end else begin
            idEx_o <= idExNext;
        end
    end

    always_comb begin
        srcA = fwdMux(fwdA_i, idEx_o.rsVal);
        storeData = fwdMux(fwdB_i, idEx_o.rtVal);
        srcB = idEx_o.ctrl.aluSrcImm ? idEx_o.imm : storeData;
    end

    aluUnit i_aluUnit (
        .op_i(idEx_o.ctrl.aluOp), .a_i(srcA), .b_i(srcB),
        .shamt_i(idEx_o.shamt), .y_o(aluY)
    );

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            exMem_o <= '0;
        end else begin
            exMem_o.regWrite <= idEx_o.ctrl.regWrite;
            exMem_o.wbSrc <= idEx_o.ctrl.wbSrc;
            exMem_o.memRead <= idEx_o.ctrl.memRead;
            exMem_o.memWrite <= idEx_o.ctrl.memWrite;
            exMem_o.aluRes <= aluY;
            exMem_o.storeData <= storeData;
            exMem_o.dst <= idEx_o.rd;
            exMem_o.pcPlus8 <= idEx_o.pcPlus8;
        end
    end

endmodule

`default_nettype wire

// File: source/memWbStage.sv
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
    input  logic            clk,
    input  logic            arstN_i,
    input  pipePkg::exMemT  exMem_i,
    input  isaPkg::wordT    dmemRdata_i,
    output logic            dmemEn_o,
    output logic            dmemWe_o,
    output isaPkg::wordT    dmemAddr_o,
    output isaPkg::wordT    dmemWdata_o,
    output isaPkg::wordT    memFwd_o,
    output logic            wbWe_o,
    output isaPkg::regAddrT wbReg_o,
    output isaPkg::wordT    wbData_o,
    output logic            wbValid_o,
    output isaPkg::wordT    wbPc_o
);
    import isaPkg::*;
    import pipePkg::*;

    memWbT memWb;

    // word accesses only, address comes straight from the ALU
    assign dmemEn_o = exMem_i.memRead || exMem_i.memWrite;
    assign dmemWe_o = exMem_i.memWrite;
    assign dmemAddr_o = exMem_i.aluRes;
    assign dmemWdata_o = exMem_i.storeData;

    // a JAL in memory forwards its link address
    assign memFwd_o = (exMem_i.wbSrc == WB_LINK) ? exMem_i.pcPlus8 : exMem_i.aluRes;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            memWb <= '0;
        end else begin
            memWb.regWrite <= exMem_i.regWrite;
            memWb.wbSrc <= exMem_i.wbSrc;
            memWb.aluRes <= exMem_i.aluRes;
            memWb.loadData <= dmemRdata_i;
            memWb.pcPlus8 <= exMem_i.pcPlus8;
            memWb.dst <= exMem_i.dst;
            memWb.pc <= exMem_i.pcPlus8 - wordT'(8);
        end
    end

    always_comb begin
        case (memWb.wbSrc)
            WB_MEM:  wbData_o = memWb.loadData;
            WB_LINK: wbData_o = memWb.pcPlus8;
            default: wbData_o = memWb.aluRes;
        endcase
    end

    assign wbWe_o = memWb.regWrite;
    assign wbReg_o = memWb.dst;
    // writes to register 0 are not reported
    assign wbValid_o = memWb.regWrite && (memWb.dst != '0);
    assign wbPc_o = memWb.pc;

endmodule

`default_nettype wire

// File: source/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
    input  logic            clk,
    input  logic            arstN_i,
    output isaPkg::wordT    imemAddr_o,
    input  isaPkg::wordT    imemData_i,
    output logic            dmemEn_o,
    output logic            dmemWe_o,
    output isaPkg::wordT    dmemAddr_o,
    output isaPkg::wordT    dmemWdata_o,
    input  isaPkg::wordT    dmemRdata_i,
    output logic            wbValid_o,
    output isaPkg::regAddrT wbReg_o,
    output isaPkg::wordT    wbData_o,
    output isaPkg::wordT    wbPc_o
);
    import isaPkg::*;
    import pipePkg::*;

    // decode stage
    instrT  instrD;
    wordT   pcPlus4D;
    ctrlT   ctrlD;
    wordT   rsValD;
    wordT   rtValD;

    // hazard controls
    logic   stallF;
    logic   stallD;
    logic   flushE;
    fwdSelE fwdA;
    fwdSelE fwdB;
    logic   brFwdA;
    logic   brFwdB;

    // later stages
    idExT   idEx;
    exMemT  exMem;
    wordT   memFwd;
    logic   wbWe;

    fetchStage i_fetchStage (
        .clk(clk), .arstN_i(arstN_i), .stallF_i(stallF), .stallD_i(stallD),
        .imemData_i(imemData_i), .ctrl_i(ctrlD), .rsVal_i(rsValD), .rtVal_i(rtValD),
        .fwdData_i(memFwd), .fwdA_i(brFwdA), .fwdB_i(brFwdB),
        .imemAddr_o(imemAddr_o), .instrD_o(instrD), .pcPlus4D_o(pcPlus4D)
    );

    instrDecoder i_instrDecoder (.instr_i(instrD), .ctrl_o(ctrlD));

    regFile i_regFile (
        .clk(clk), .arstN_i(arstN_i), .raddrA_i(instrD.rs), .raddrB_i(instrD.rt),
        .we_i(wbWe), .waddr_i(wbReg_o), .wdata_i(wbData_o),
        .rdataA_o(rsValD), .rdataB_o(rtValD)
    );

    hazardUnit i_hazardUnit (
        .rsD_i(instrD.rs), .rtD_i(instrD.rt), .ctrlD_i(ctrlD), .idEx_i(idEx),
        .exMem_i(exMem), .wbWe_i(wbWe), .wbReg_i(wbReg_o),
        .stallF_o(stallF), .stallD_o(stallD), .flushE_o(flushE),
        .fwdA_o(fwdA), .fwdB_o(fwdB), .brFwdA_o(brFwdA), .brFwdB_o(brFwdB)
    );

    executeStage i_executeStage (
        .clk(clk), .arstN_i(arstN_i), .flushE_i(flushE), .ctrl_i(ctrlD),
        .rsVal_i(rsValD), .rtVal_i(rtValD), .instrD_i(instrD), .pcPlus4D_i(pcPlus4D),
        .fwdA_i(fwdA), .fwdB_i(fwdB), .memFwd_i(memFwd), .wbFwd_i(wbData_o),
        .idEx_o(idEx), .exMem_o(exMem)
    );

    memWbStage i_memWbStage (
        .clk(clk), .arstN_i(arstN_i), .exMem_i(exMem), .dmemRdata_i(dmemRdata_i),
        .dmemEn_o(dmemEn_o), .dmemWe_o(dmemWe_o), .dmemAddr_o(dmemAddr_o),
        .dmemWdata_o(dmemWdata_o), .memFwd_o(memFwd), .wbWe_o(wbWe),
        .wbReg_o(wbReg_o), .wbData_o(wbData_o), .wbValid_o(wbValid_o), .wbPc_o(wbPc_o)
    );

endmodule

`default_nettype wire

// File: tests/coreChecker.sv
`timescale 1ns/1ps
`default_nettype none

module coreChecker (
    input  logic        clk,
    input  logic        arstN_i,
    input  logic        wbValid_i,
    input  logic [4:0]  wbReg_i,
    input  logic [31:0] wbData_i,
    input  logic [31:0] wbPc_i,
    input  logic        dmemEn_i,
    input  logic        dmemWe_i,
    output int          seen_o,
    output int          failCount_o
);
    localparam int MAX_EXP = 8;

    string       name;
    logic [4:0]  expReg [MAX_EXP];
    logic [31:0] expVal [MAX_EXP];
    logic [31:0] firstPc;
    int          expCount;
    int          expStores;
    int          stores;
    int          errs;
    int          passCount;

    task automatic startTest(input string testName, input int count,
                             input logic [31:0] pc0, input int storeCount);
        name = testName;
        expCount = count;
        firstPc = pc0;
        expStores = storeCount;
    endtask

    task automatic setExpect(input int idx, input logic [4:0] r, input logic [31:0] v);
        expReg[idx] = r;
        expVal[idx] = v;
    endtask

    // trace and memory outputs only move on rising edges
    always @(posedge clk) begin
        if (!arstN_i) begin
            seen_o = 0;
            stores = 0;
            errs = 0;
        end else begin
            if (dmemEn_i && dmemWe_i) begin
                stores++;
            end
            if (wbValid_i) begin
                if (seen_o >= expCount) begin
                    $display("%s: unexpected writeback of r%0d from pc %h", name, wbReg_i, wbPc_i);
                    errs++;
                end else if ((wbReg_i !== expReg[seen_o]) || (wbData_i !== expVal[seen_o])) begin
                    $display("ERR %s: writeback %0d expected r%0d=%h, actual r%0d=%h", name,
                             seen_o, expReg[seen_o], expVal[seen_o], wbReg_i, wbData_i);
                    errs++;
                end
                // first retired instruction must come from the start of the program
                if ((seen_o == 0) && (wbPc_i !== firstPc)) begin
                    $display("ERR %s: first writeback pc expected %h, actual %h", name,
                             firstPc, wbPc_i);
                    errs++;
                end
                seen_o++;
            end
        end
    end

    task automatic finishTest();
        int bad;
        bad = errs;
        if (seen_o < expCount) begin
            $display("%s: %0d expected writebacks never appeared", name, expCount - seen_o);
            bad++;
        end
        if (stores != expStores) begin
            $display("%s: saw %0d data memory writes but the program stores %0d words", name,
                     stores, expStores);
            bad++;
        end
        if (bad == 0) begin
            passCount++;
            $display("test %s: pass", name);
        end else begin
            failCount_o++;
            $display("test %s: fail with %0d errors", name, bad);
        end
    endtask

    task automatic report();
        $display("tests passed: %0d, tests failed: %0d", passCount, failCount_o);
    endtask

endmodule

`default_nettype wire

// File: tests/tbMipsCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsCore_cfg.svh"

module tbMipsCore;

    typedef logic [31:0] wordT;

    localparam int NUM_TESTS = 6;
    localparam int PROG_WORDS = 12;
    localparam int MAX_EXP = 8;
    localparam int MEM_WORDS = 64;
    localparam int DRAIN_CYCLES = 6;
    // each program word costs at most three cycles
    localparam int RUN_CYCLES = PROG_WORDS * 3;
    // three cycles per program word plus fill and reset overhead
    localparam int CYCLE_LIMIT = NUM_TESTS * (PROG_WORDS * 3 + 20);
    localparam wordT NOP = 32'h0000_0000;

    // MIPS32 opcodes
    localparam int OP_J = 'h02;
    localparam int OP_JAL = 'h03;
    localparam int OP_BEQ = 'h04;
    localparam int OP_BNE = 'h05;
    localparam int OP_ADDIU = 'h09;
    localparam int OP_ANDI = 'h0c;
    localparam int OP_ORI = 'h0d;
    localparam int OP_LUI = 'h0f;
    localparam int OP_LW = 'h23;
    localparam int OP_SW = 'h2b;
    // R-type function codes
    localparam int F_SLL = 'h00;
    localparam int F_ADDU = 'h21;
    localparam int F_SUBU = 'h23;
    localparam int F_AND = 'h24;
    localparam int F_OR = 'h25;
    localparam int F_XOR = 'h26;
    localparam int F_SLT = 'h2a;

    logic       clk = 1'b0;
    logic       arstN;
    wordT       imemAddr;
    wordT       imemData;
    logic       dmemEn;
    logic       dmemWe;
    wordT       dmemAddr;
    wordT       dmemWdata;
    wordT       dmemRdata;
    logic       wbValid;
    logic [4:0] wbReg;
    wordT       wbData;
    wordT       wbPc;
    int         seenCount;
    int         failCount;
    int         cycles = 0;

    wordT imem [MEM_WORDS];
    wordT dmem [MEM_WORDS];

    // test table
    string      testName [NUM_TESTS];
    wordT       progTable [NUM_TESTS][PROG_WORDS];
    logic [4:0] expReg [NUM_TESTS][MAX_EXP];
    wordT       expVal [NUM_TESTS][MAX_EXP];
    int         expCount [NUM_TESTS];
    wordT       firstPc [NUM_TESTS];

    always #50 clk = ~clk;

    mipsCore i_mipsCore (
        .clk(clk), .arstN_i(arstN), .imemAddr_o(imemAddr), .imemData_i(imemData),
        .dmemEn_o(dmemEn), .dmemWe_o(dmemWe), .dmemAddr_o(dmemAddr),
        .dmemWdata_o(dmemWdata), .dmemRdata_i(dmemRdata), .wbValid_o(wbValid),
        .wbReg_o(wbReg), .wbData_o(wbData), .wbPc_o(wbPc)
    );

    coreChecker i_coreChecker (
        .clk(clk), .arstN_i(arstN), .wbValid_i(wbValid), .wbReg_i(wbReg),
        .wbData_i(wbData), .wbPc_i(wbPc), .dmemEn_i(dmemEn), .dmemWe_i(dmemWe),
        .seen_o(seenCount), .failCount_o(failCount)
    );

    // single-cycle memories indexed by address bits 7:2
    assign imemData = imem[imemAddr[7:2]];
    assign dmemRdata = dmemEn ? dmem[dmemAddr[7:2]] : '0;

    always @(posedge clk) begin
        if (dmemEn && dmemWe) begin
            dmem[dmemAddr[7:2]] <= dmemWdata;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // encoders take register arguments in assembly order
    function automatic wordT rIns(input int fn, input int rd, input int rs, input int rt,
                                  input int sh);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
    endfunction

    function automatic wordT iIns(input int op, input int rt, input int rs, input int imm);
        return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic wordT jIns(input int op, input int wordIdx);
        return {6'(op), 26'(wordIdx)};
    endfunction

    function automatic int countStores(input int t);
        int n;
        n = 0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            if (progTable[t][i][31:26] == 6'(OP_SW)) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic clearMemories();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = NOP;
            dmem[i] = '0;
        end
    endtask

    task automatic buildTable();
        testName[0] = "aluForwardA";
        progTable[0] = '{
            iIns(OP_ADDIU, 1, 0, 5), iIns(OP_ADDIU, 2, 1, 3), rIns(F_ADDU, 3, 1, 2, 0),
            rIns(F_SUBU, 4, 0, 3, 0), rIns(F_AND, 5, 4, 3, 0), rIns(F_OR, 6, 5, 2, 0),
            rIns(F_XOR, 7, 6, 3, 0), rIns(F_SLT, 8, 4, 7, 0), NOP, NOP, NOP, NOP};
        expReg[0] = '{1, 2, 3, 4, 5, 6, 7, 8};
        expVal[0] = '{5, 8, 13, 32'hffff_fff3, 1, 9, 4, 1};
        expCount[0] = 8;

        testName[1] = "aluForwardB";
        progTable[1] = '{
            iIns(OP_LUI, 1, 0, 'h1234), iIns(OP_ORI, 2, 1, 'h5678), iIns(OP_ANDI, 3, 2, 'hff0f),
            rIns(F_SLL, 4, 0, 3, 4), iIns(OP_ADDIU, 5, 4, -1), rIns(F_SLT, 6, 5, 4, 0),
            rIns(F_SLT, 7, 4, 5, 0), rIns(F_XOR, 8, 2, 1, 0), NOP, NOP, NOP, NOP};
        expReg[1] = '{1, 2, 3, 4, 5, 6, 7, 8};
        expVal[1] = '{32'h1234_0000, 32'h1234_5678, 'h5608, 'h5_6080, 'h5_607f, 1, 0, 'h5678};
        expCount[1] = 8;

        // store then load the same word and use each load at once
        testName[2] = "loadStore";
        progTable[2] = '{
            iIns(OP_ADDIU, 1, 0, 'h40), iIns(OP_ADDIU, 2, 0, 'h7abc), iIns(OP_SW, 2, 1, 4),
            iIns(OP_LW, 3, 1, 4), rIns(F_ADDU, 4, 3, 3, 0), iIns(OP_SW, 4, 1, 0),
            iIns(OP_LW, 5, 1, 0), rIns(F_SUBU, 6, 5, 2, 0), NOP, NOP, NOP, NOP};
        expReg[2] = '{1, 2, 3, 4, 5, 6, 0, 0};
        expVal[2] = '{'h40, 'h7abc, 'h7abc, 'hf578, 'hf578, 'h7abc, 0, 0};
        expCount[2] = 6;

        // words 4 and 10 sit behind taken branches
        testName[3] = "branches";
        progTable[3] = '{
            iIns(OP_ADDIU, 1, 0, 1), iIns(OP_ADDIU, 2, 0, 1), iIns(OP_BEQ, 2, 1, 2),
            iIns(OP_ADDIU, 3, 0, 3), iIns(OP_ADDIU, 4, 0, 4), iIns(OP_BNE, 2, 1, 5),
            iIns(OP_ADDIU, 5, 0, 5), iIns(OP_ADDIU, 6, 0, 6), iIns(OP_BNE, 0, 6, 2),
            iIns(OP_ADDIU, 7, 0, 7), iIns(OP_ADDIU, 8, 0, 8), iIns(OP_ADDIU, 9, 0, 9)};
        expReg[3] = '{1, 2, 3, 5, 6, 7, 9, 0};
        expVal[3] = '{1, 1, 3, 5, 6, 7, 9, 0};
        expCount[3] = 7;

        // JAL at byte 16 links 24, the BEQ at word 8 falls through
        testName[4] = "jumps";
        progTable[4] = '{
            iIns(OP_ADDIU, 1, 0, 1), jIns(OP_J, 4), iIns(OP_ADDIU, 2, 0, 2),
            iIns(OP_ADDIU, 3, 0, 3), jIns(OP_JAL, 7), iIns(OP_ADDIU, 4, 0, 4),
            iIns(OP_ADDIU, 5, 0, 5), rIns(F_ADDU, 6, 31, 1, 0), iIns(OP_BEQ, 1, 6, 2),
            iIns(OP_ADDIU, 7, 0, 7), iIns(OP_ADDIU, 8, 0, 8), NOP};
        expReg[4] = '{1, 2, 31, 4, 6, 7, 8, 0};
        expVal[4] = '{1, 2, 24, 4, 25, 7, 8, 0};
        expCount[4] = 7;

        testName[5] = "regZero";
        progTable[5] = '{
            iIns(OP_ADDIU, 0, 0, 7), rIns(F_ADDU, 1, 0, 0, 0), iIns(OP_ADDIU, 2, 0, 9),
            iIns(OP_ORI, 0, 2, 'hff), iIns(OP_ADDIU, 3, 0, 1), NOP, NOP, NOP, NOP,
            NOP, NOP, NOP};
        expReg[5] = '{1, 2, 3, 0, 0, 0, 0, 0};
        expVal[5] = '{0, 9, 1, 0, 0, 0, 0, 0};
        expCount[5] = 3;

        for (int t = 0; t < NUM_TESTS; t++) begin
            firstPc[t] = `RESET_PC;
        end
        // first word writes r0 and retires silently
        firstPc[5] = `RESET_PC + 4;
    endtask

    task automatic runTest(input int t);
        int waited;
        @(negedge clk);
        arstN = 1'b0;
        clearMemories();
        for (int i = 0; i < PROG_WORDS; i++) begin
            imem[i] = progTable[t][i];
        end
        i_coreChecker.startTest(testName[t], expCount[t], firstPc[t], countStores(t));
        for (int i = 0; i < MAX_EXP; i++) begin
            i_coreChecker.setExpect(i, expReg[t][i], expVal[t][i]);
        end
        repeat (3) @(negedge clk);
        arstN = 1'b1;
        waited = 0;
        while ((seenCount < expCount[t]) && (waited < RUN_CYCLES)) begin
            @(negedge clk);
            waited++;
        end
        // let stray writebacks and stores show up
        repeat (DRAIN_CYCLES) @(negedge clk);
        i_coreChecker.finishTest();
    endtask

    initial begin
        arstN = 1'b0;
        clearMemories();
        buildTable();
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        i_coreChecker.report();
        if (failCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
source/isaPkg.sv
source/pipePkg.sv
source/instrDecoder.sv
source/regFile.sv
source/aluUnit.sv
source/hazardUnit.sv
source/fetchStage.sv
source/executeStage.sv
source/memWbStage.sv
source/mipsCore.sv
tests/coreChecker.sv
tests/tbMipsCore.sv
